/* verilog/scaler_pkg.sv */
package scaler_pkg;

    // sample, gain and offset all share this width
    localparam int SAMPLE_W  = 16;
    localparam int GAIN_FRAC = 8;  // fractional bits of the q8.8 gain

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // result word leaving the gain stage
    typedef struct packed {
        sample_t data;  // scaled, offset and clipped value
        logic    sat;   // set when data was clipped
    } result_t;

    // register map on a 2-bit address
    localparam logic [1:0] ADDR_GAIN   = 2'd0;
    localparam logic [1:0] ADDR_OFFSET = 2'd1;
    localparam logic [1:0] ADDR_CTRL   = 2'd2;  // bit 0 is enable
    localparam logic [1:0] ADDR_SATCNT = 2'd3;  // write clears

    // unity gain in q8.8
    localparam sample_t GAIN_RESET = sample_t'(1 << GAIN_FRAC);

endpackage

/* verilog/scaler_cfg_if.sv */
`timescale 1ns/1ps

interface scaler_cfg_if;

    import scaler_pkg::*;

    sample_t gain;       // q8.8
    sample_t offset;     // added after the shift
    logic    enable;     // 0 passes samples through
    logic    sat_pulse;  // one cycle per clipped result leaving the stage

    // register block side
    modport regs (
        output gain,
        output offset,
        output enable,
        input  sat_pulse
    );

    // gain stage side
    modport stage (
        input  gain,
        input  offset,
        input  enable,
        output sat_pulse
    );

endinterface

/* verilog/fifo.sv */
`timescale 1ns/1ps

module fifo #(
    parameter type payload_t    = logic [7:0],
    parameter int  DEPTH        = 4,
    parameter bit  BYPASS_EMPTY = 1'b1
) (
    input  logic     clk_i,
    input  logic     arst_n,

    input  payload_t data_in,
    input  logic     data_in_valid,
    output logic     data_in_ready,

    output payload_t data_out,
    output logic     data_out_valid,
    input  logic     data_out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];  // circular storage, no reset

    logic [CNT_W-1:0] dt_cnt;  // fill level
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr_next;
    logic [PTR_W-1:0] rd_ptr_next;

    logic empty;
    logic full;
    logic data_in_hs;
    logic data_out_hs;

    assign empty = (dt_cnt == '0);
    assign full  = (dt_cnt == CNT_W'(DEPTH));

    // full still takes a word when the head leaves this cycle
    assign data_in_ready = full ? data_out_ready : 1'b1;

    // bypass path when nothing is stored
    assign data_out_valid = empty ? (BYPASS_EMPTY & data_in_valid) : 1'b1;
    assign data_out       = (empty && BYPASS_EMPTY) ? data_in : mem[rd_ptr];

    assign data_in_hs  = data_in_valid  & data_in_ready;
    assign data_out_hs = data_out_valid & data_out_ready;

    // wrap at depth, depth need not be a power of two
    assign wr_ptr_next = (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
    assign rd_ptr_next = (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            dt_cnt <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (data_in_hs) begin
                wr_ptr <= wr_ptr_next;
            end
            if (data_out_hs) begin
                rd_ptr <= rd_ptr_next;
            end
            // level only moves when exactly one side transfers
            case ({data_out_hs, data_in_hs})
                2'b01:   dt_cnt <= dt_cnt + 1'b1;
                2'b10:   dt_cnt <= dt_cnt - 1'b1;
                default: dt_cnt <= dt_cnt;
            endcase
        end
    end

    // bypassed words are written too, the read pointer skips them in step
    always_ff @(posedge clk_i) begin
        if (data_in_hs) begin
            mem[wr_ptr] <= data_in;
        end
    end

endmodule

/* verilog/scaler_regs.sv */
`timescale 1ns/1ps

module scaler_regs (
    input  logic                           clk_i,
    input  logic                           arst_n,

    input  logic                           cfg_wr,     // one-cycle write strobe
    input  logic [1:0]                     cfg_addr,
    input  logic [scaler_pkg::SAMPLE_W-1:0] cfg_wdata,
    output logic [scaler_pkg::SAMPLE_W-1:0] cfg_rdata,  // combinational read

    scaler_cfg_if.regs                     cfg
);

    import scaler_pkg::*;

    sample_t             gain_q;
    sample_t             offset_q;
    logic                enable_q;
    logic [SAMPLE_W-1:0] sat_cnt;  // sticks at all ones

    logic sat_clr;

    assign sat_clr = cfg_wr && (cfg_addr == ADDR_SATCNT);

    // config registers
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            gain_q   <= GAIN_RESET;
            offset_q <= '0;
            enable_q <= 1'b1;
        end else if (cfg_wr) begin
            case (cfg_addr)
                ADDR_GAIN:   gain_q   <= sample_t'(cfg_wdata);
                ADDR_OFFSET: offset_q <= sample_t'(cfg_wdata);
                ADDR_CTRL:   enable_q <= cfg_wdata[0];
                default:     ;  // counter clear handled below
            endcase
        end
    end

    // saturation event counter
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            sat_cnt <= '0;
        end else if (sat_clr) begin
            sat_cnt <= '0;  // clear wins over a same-cycle pulse
        end else if (cfg.sat_pulse && (sat_cnt != '1)) begin
            sat_cnt <= sat_cnt + 1'b1;
        end
    end

    assign cfg.gain   = gain_q;
    assign cfg.offset = offset_q;
    assign cfg.enable = enable_q;

    // read mux
    always_comb begin
        case (cfg_addr)
            ADDR_GAIN:   cfg_rdata = gain_q;
            ADDR_OFFSET: cfg_rdata = offset_q;
            ADDR_CTRL:   cfg_rdata = {{(SAMPLE_W-1){1'b0}}, enable_q};
            default:     cfg_rdata = sat_cnt;
        endcase
    end

endmodule

/* verilog/gain_stage.sv */
`timescale 1ns/1ps

module gain_stage (
    input  logic                clk_i,
    input  logic                arst_n,

    input  scaler_pkg::sample_t s_data,
    input  logic                s_valid,
    output logic                s_ready,

    output scaler_pkg::result_t m_data,
    output logic                m_valid,
    input  logic                m_ready,

    scaler_cfg_if.stage         cfg
);

    import scaler_pkg::*;

    localparam int PROD_W = 2 * SAMPLE_W;
    localparam int SUM_W  = PROD_W + 1;  // one guard bit for the offset add

    localparam logic signed [SUM_W-1:0] SAT_MAX = (1 <<< (SAMPLE_W - 1)) - 1;
    localparam logic signed [SUM_W-1:0] SAT_MIN = -(1 <<< (SAMPLE_W - 1));

    // stage 1 state
    logic                     v1;
    logic signed [PROD_W-1:0] prod_q;
    logic                     en1;  // enable seen by this sample

    // stage 2 state
    logic                     v2;
    result_t                  res_q;

    // stall control
    logic ready2;  // stage 2 can take a new item
    logic load1;
    logic load2;

    // stage 1 math
    sample_t                  mult;
    logic signed [PROD_W-1:0] prod_d;

    // stage 2 math
    logic signed [PROD_W-1:0] shifted;
    sample_t                  offset_term;
    logic signed [SUM_W-1:0]  sum;
    result_t                  res_d;

    assign ready2  = ~v2 | m_ready;
    assign s_ready = ~v1 | ready2;  // stage 1 moves when empty or stage 2 moves

    assign load1 = s_valid & s_ready;
    assign load2 = v1 & ready2;

    // disabled samples go through with unity gain, shift restores them exactly
    assign mult   = cfg.enable ? cfg.gain : GAIN_RESET;
    assign prod_d = s_data * mult;  // full-width signed product

    // arithmetic shift rounds toward minus infinity
    assign shifted     = prod_q >>> GAIN_FRAC;
    assign offset_term = en1 ? cfg.offset : '0;
    assign sum         = shifted + offset_term;

    // clip to the sample range
    always_comb begin
        if (sum > SAT_MAX) begin
            res_d.data = sample_t'(SAT_MAX);
            res_d.sat  = 1'b1;
        end else if (sum < SAT_MIN) begin
            res_d.data = sample_t'(SAT_MIN);
            res_d.sat  = 1'b1;
        end else begin
            res_d.data = sample_t'(sum);
            res_d.sat  = 1'b0;
        end
    end

    // valid bits
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
        end else begin
            if (s_ready) begin
                v1 <= s_valid;
            end
            if (ready2) begin
                v2 <= v1;
            end
        end
    end

    // payload, held in place while stalled
    always_ff @(posedge clk_i) begin
        if (load1) begin
            prod_q <= prod_d;
            en1    <= cfg.enable;
        end
        if (load2) begin
            res_q <= res_d;
        end
    end

    assign m_data  = res_q;
    assign m_valid = v2;

    // counted once, on the transfer out of stage 2
    assign cfg.sat_pulse = v2 & m_ready & res_q.sat;

endmodule

/* verilog/sample_scaler_top.sv */
`timescale 1ns/1ps

module sample_scaler_top #(
    parameter int IN_DEPTH  = 4,
    parameter int OUT_DEPTH = 4
) (
    input  logic                            clk_i,
    input  logic                            arst_n,

    // input stream
    input  scaler_pkg::sample_t             in_data,
    input  logic                            in_valid,
    output logic                            in_ready,

    // output stream
    output scaler_pkg::sample_t             out_data,
    output logic                            out_sat,
    output logic                            out_valid,
    input  logic                            out_ready,

    // configuration
    input  logic                            cfg_wr,
    input  logic [1:0]                      cfg_addr,
    input  logic [scaler_pkg::SAMPLE_W-1:0] cfg_wdata,
    output logic [scaler_pkg::SAMPLE_W-1:0] cfg_rdata
);

    import scaler_pkg::*;

    // input fifo to gain stage
    sample_t fifo_s_data;
    logic    fifo_s_valid;
    logic    fifo_s_ready;

    // gain stage to output fifo
    result_t gs_m_data;
    logic    gs_m_valid;
    logic    gs_m_ready;

    result_t out_res;  // split onto the data and sat ports

    scaler_cfg_if cfg_if ();

    fifo #(
        .payload_t    (sample_t),
        .DEPTH        (IN_DEPTH),
        .BYPASS_EMPTY (1'b1)
    ) i_in_fifo (
        .clk_i          (clk_i),
        .arst_n         (arst_n),
        .data_in        (in_data),
        .data_in_valid  (in_valid),
        .data_in_ready  (in_ready),
        .data_out       (fifo_s_data),
        .data_out_valid (fifo_s_valid),
        .data_out_ready (fifo_s_ready)
    );

    gain_stage i_gain_stage (
        .clk_i   (clk_i),
        .arst_n  (arst_n),
        .s_data  (fifo_s_data),
        .s_valid (fifo_s_valid),
        .s_ready (fifo_s_ready),
        .m_data  (gs_m_data),
        .m_valid (gs_m_valid),
        .m_ready (gs_m_ready),
        .cfg     (cfg_if.stage)
    );

    fifo #(
        .payload_t    (result_t),
        .DEPTH        (OUT_DEPTH),
        .BYPASS_EMPTY (1'b1)
    ) i_out_fifo (
        .clk_i          (clk_i),
        .arst_n         (arst_n),
        .data_in        (gs_m_data),
        .data_in_valid  (gs_m_valid),
        .data_in_ready  (gs_m_ready),
        .data_out       (out_res),
        .data_out_valid (out_valid),
        .data_out_ready (out_ready)
    );

    scaler_regs i_regs (
        .clk_i     (clk_i),
        .arst_n    (arst_n),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .cfg       (cfg_if.regs)
    );

    assign out_data = out_res.data;
    assign out_sat  = out_res.sat;

endmodule

/* test/sample_scaler_properties.sv */
`timescale 1ns/1ps

module sample_scaler_properties (
    input logic                clk_i,
    input logic                arst_n,
    input scaler_pkg::sample_t out_data,
    input logic                out_sat,
    input logic                out_valid,
    input logic                out_ready
);

    // a stalled output word must not move
    a_hold_data: assert property (@(posedge clk_i) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("out_valid or out_data changed while stalled");

    a_hold_sat: assert property (@(posedge clk_i) disable iff (!arst_n)
        (out_valid && !out_ready) |=> $stable(out_sat))
        else $error("out_sat changed while stalled");

    // valid driven from reset flops, never x
    a_valid_known: assert property (@(posedge clk_i) disable iff (!arst_n)
        !$isunknown(out_valid))
        else $error("out_valid is unknown after reset");

endmodule

bind sample_scaler_top sample_scaler_properties i_props (
    .clk_i     (clk_i),
    .arst_n    (arst_n),
    .out_data  (out_data),
    .out_sat   (out_sat),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

/* test/tb_sample_scaler.sv */
`timescale 1ns/1ps

module tb_sample_scaler;

    import scaler_pkg::*;

    localparam int IN_DEPTH  = 4;
    localparam int OUT_DEPTH = 4;
    localparam int TIMEOUT   = 2000;  // cycles allowed per wait

    logic                clk_i;
    logic                arst_n;
    sample_t             in_data;
    logic                in_valid;
    logic                in_ready;
    sample_t             out_data;
    logic                out_sat;
    logic                out_valid;
    logic                out_ready;
    logic                cfg_wr;
    logic [1:0]          cfg_addr;
    logic [SAMPLE_W-1:0] cfg_wdata;
    logic [SAMPLE_W-1:0] cfg_rdata;

    result_t exp_q[$];    // expected results with the oldest first
    sample_t gain_sh;     // copy of what was written to the DUT
    sample_t offset_sh;
    logic    enable_sh;
    logic    bp_random;   // random out_ready when set
    int      pass_cnt;
    int      fail_cnt;
    int      sat_seen;    // sat results at the output

    sample_scaler_top #(
        .IN_DEPTH  (IN_DEPTH),
        .OUT_DEPTH (OUT_DEPTH)
    ) i_dut (.*);

    always #2 clk_i = ~clk_i;  // 4 ns period

    // q8.8 multiply, floor shift, offset, clip to 16 bits
    function automatic result_t scale_ref(input sample_t s, input sample_t g,
                                          input sample_t ofs, input logic en);
        longint  val;
        longint  lim_hi;
        longint  lim_lo;
        result_t r;
        lim_hi = (longint'(1) << (SAMPLE_W - 1)) - 1;
        lim_lo = -(longint'(1) << (SAMPLE_W - 1));
        val    = ((longint'(s) * longint'(g)) >>> GAIN_FRAC) + longint'(ofs);
        r.sat  = 1'b0;
        if (!en) begin
            r.data = s;  // bypass leaves the sample alone
        end else if (val > lim_hi) begin
            r.data = sample_t'(lim_hi);
            r.sat  = 1'b1;
        end else if (val < lim_lo) begin
            r.data = sample_t'(lim_lo);
            r.sat  = 1'b1;
        end else begin
            r.data = sample_t'(val);
        end
        return r;
    endfunction

    task automatic end_on_timeout(input string what);
        $display("timeout at t=%0t: %s", $time, what);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    // four-state compare so an x on the DUT side is caught
    task automatic check_value(input string name, input logic [31:0] expd,
                               input logic [31:0] act);
        if (expd !== act) begin
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, expd, act);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    // all tasks start and end 1 ns after a rising edge
    task automatic write_reg(input logic [1:0] addr, input sample_t data);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        case (addr)
            ADDR_GAIN:   gain_sh   = data;
            ADDR_OFFSET: offset_sh = data;
            ADDR_CTRL:   enable_sh = data[0];
            default:     ;
        endcase
        @(posedge clk_i);
        #1;
        cfg_wr = 1'b0;
    endtask

    task automatic read_reg(input logic [1:0] addr, output logic [31:0] data);
        cfg_addr = addr;
        @(negedge clk_i);
        data = cfg_rdata;  // zero extended so counts above 32767 stay positive
        @(posedge clk_i);
        #1;
    endtask

    task automatic send_sample(input sample_t s);
        int waited;
        waited   = 0;
        in_data  = s;
        in_valid = 1'b1;
        @(negedge clk_i);
        while (!in_ready) begin
            waited++;
            if (waited > TIMEOUT) end_on_timeout("in_ready stayed low while sending a sample");
            @(negedge clk_i);
        end
        exp_q.push_back(scale_ref(s, gain_sh, offset_sh, enable_sh));  // taken at next edge
        @(posedge clk_i);
        #1;
    endtask

    task automatic wait_drain();
        int waited;
        waited   = 0;
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > TIMEOUT) end_on_timeout("results missing, scoreboard never drained");
            @(posedge clk_i);
        end
        @(posedge clk_i);
        #1;
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (fail_cnt == fails_before) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, fail_cnt - fails_before);
    endtask

    // random back-pressure on out_ready
    always @(posedge clk_i) begin
        #1;
        if (bp_random) out_ready = ($urandom_range(0, 3) != 0);
    end

    // scoreboard samples mid-cycle where everything is settled
    always @(negedge clk_i) begin
        result_t expd;
        if (arst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("output transfer at t=%0t with no sample pending", $time);
                fail_cnt++;
            end else begin
                expd = exp_q.pop_front();
                if (out_data !== expd.data) begin
                    $display("FAIL t=%0t out_data expected %0d got %0d",
                             $time, expd.data, out_data);
                    fail_cnt++;
                end else begin
                    pass_cnt++;
                end
                if (out_sat !== expd.sat) begin
                    $display("FAIL t=%0t out_sat expected %0b got %0b", $time, expd.sat, out_sat);
                    fail_cnt++;
                end else begin
                    pass_cnt++;
                end
                if (out_sat === 1'b1) sat_seen++;
            end
        end
    end

    initial begin
        logic [31:0] rd;
        int          mark;
        int          accepted;
        int          idle;
        int          loops;
        sample_t     s;
        void'($urandom(17603));
        clk_i     = 1'b0;
        arst_n    = 1'b0;
        in_data   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        cfg_wr    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        bp_random = 1'b0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        sat_seen  = 0;
        gain_sh   = GAIN_RESET;
        offset_sh = '0;
        enable_sh = 1'b1;
        repeat (16) @(posedge clk_i);
        #1;
        arst_n = 1'b1;

        // test 1 covers reset values
        mark = fail_cnt;
        @(negedge clk_i);
        check_value("out_valid", 0, out_valid);
        check_value("in_ready", 1, in_ready);
        @(posedge clk_i);
        #1;
        read_reg(ADDR_GAIN, rd);
        check_value("cfg_rdata(gain)", 256, rd);
        read_reg(ADDR_OFFSET, rd);
        check_value("cfg_rdata(offset)", 0, rd);
        read_reg(ADDR_CTRL, rd);
        check_value("cfg_rdata(ctrl)", 1, rd);
        read_reg(ADDR_SATCNT, rd);
        check_value("cfg_rdata(satcnt)", 0, rd);
        report_test("1 reset state", mark);

        // test 2 passes samples through at unity gain
        mark = fail_cnt;
        for (int i = 0; i < 50; i++) send_sample(sample_t'($urandom));
        wait_drain();
        report_test("2 default passthrough", mark);

        // test 3 uses random gain and offset under back-pressure
        mark = fail_cnt;
        s = sample_t'($urandom_range(0, 1023));
        if ($urandom_range(0, 1)) s = -s;
        write_reg(ADDR_GAIN, s);
        write_reg(ADDR_OFFSET, sample_t'($urandom_range(0, 8191) - 4096));
        bp_random = 1'b1;
        for (int i = 0; i < 200; i++) send_sample(sample_t'($urandom));
        wait_drain();
        bp_random = 1'b0;
        out_ready = 1'b1;
        report_test("3 random gain and offset", mark);

        // test 4 clips both ways with a gain of 64
        mark = fail_cnt;
        write_reg(ADDR_GAIN, sample_t'(16'h4000));
        write_reg(ADDR_OFFSET, '0);
        write_reg(ADDR_SATCNT, '0);  // drop counts from test 3
        sat_seen = 0;
        for (int i = 0; i < 20; i++) begin
            s = sample_t'($urandom_range(1000, 32767));
            send_sample((i % 2) ? -s : s);
        end
        wait_drain();
        check_value("sat results", 20, sat_seen);
        read_reg(ADDR_SATCNT, rd);
        check_value("cfg_rdata(satcnt)", sat_seen, rd);
        write_reg(ADDR_SATCNT, '0);
        read_reg(ADDR_SATCNT, rd);
        check_value("cfg_rdata(satcnt) after clear", 0, rd);
        report_test("4 saturation", mark);

        // test 5 disables the stage so gain and offset are ignored
        mark = fail_cnt;
        write_reg(ADDR_GAIN, sample_t'(16'h0300));
        write_reg(ADDR_OFFSET, sample_t'(100));
        write_reg(ADDR_CTRL, '0);
        bp_random = 1'b1;
        for (int i = 0; i < 30; i++) send_sample(sample_t'($urandom));
        wait_drain();
        bp_random = 1'b0;
        out_ready = 1'b1;
        report_test("5 enable off", mark);

        // test 6 fills everything with out_ready low and then drains
        mark = fail_cnt;
        write_reg(ADDR_CTRL, sample_t'(1));
        write_reg(ADDR_GAIN, GAIN_RESET);
        write_reg(ADDR_OFFSET, '0);
        out_ready = 1'b0;
        accepted  = 0;
        idle      = 0;
        loops     = 0;
        in_valid  = 1'b1;
        in_data   = sample_t'($urandom);
        while (idle < 20) begin  // in_ready low for 20 cycles counts as stuck
            loops++;
            if (loops > TIMEOUT) end_on_timeout("in_ready never stayed low under back-pressure");
            @(negedge clk_i);
            if (in_ready) begin
                exp_q.push_back(scale_ref(in_data, gain_sh, offset_sh, enable_sh));
                accepted++;
                idle = 0;
            end else begin
                idle++;
            end
            @(posedge clk_i);
            #1;
            if (idle == 0) in_data = sample_t'($urandom);  // hold data until taken
        end
        in_valid = 1'b0;
        check_value("accepted samples", IN_DEPTH + 2 + OUT_DEPTH, accepted);
        out_ready = 1'b1;
        wait_drain();
        report_test("6 full back-pressure", mark);

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* src.f */
verilog/scaler_pkg.sv
verilog/scaler_cfg_if.sv
verilog/fifo.sv
verilog/scaler_regs.sv
verilog/gain_stage.sv
verilog/sample_scaler_top.sv
test/sample_scaler_properties.sv
test/tb_sample_scaler.sv

/* run.sh */
#!/bin/sh
# build and run the sample scaler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sample_scaler \
    -f src.f \
    -o tb_sample_scaler

out=$(./obj_dir/tb_sample_scaler)
echo "$out"

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
else
    exit 1
fi
